/* hw/issue_pkg.sv */
// shared widths, opcodes, alu encodings and instruction layouts, compiled ahead of the issue stage rtl
package issue_pkg;

    localparam int XLEN        = 32;   // datapath width
    localparam int ILEN        = 32;   // instruction word width
    localparam int REG_IDX_LEN = 5;    // 32 architectural registers

    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register alu
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate alu

    // operation carried from issue into the stations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef struct packed {
        logic [6:0]             funct7;  // bit 5 selects sub
        logic [REG_IDX_LEN-1:0] rs2;
        logic [REG_IDX_LEN-1:0] rs1;
        logic [2:0]             funct3;
        logic [REG_IDX_LEN-1:0] rd;
        logic [6:0]             opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]            imm;     // sign extended at issue
        logic [REG_IDX_LEN-1:0] rs1;
        logic [2:0]             funct3;
        logic [REG_IDX_LEN-1:0] rd;
        logic [6:0]             opcode;
    } i_type_t;

    // same word, two decodings; opcode/rd/rs1 line up in both
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

endpackage

/* hw/issue_queue.sv */
`timescale 1ns/1ps
// circular instruction fifo, filled by fetch and drained by the issue logic on dispatch
module issue_queue #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       fetch_valid_i,
    output logic                       fetch_ready_o,
    input  logic [issue_pkg::XLEN-1:0] fetch_pc_i,
    input  logic [issue_pkg::ILEN-1:0] fetch_instr_i,
    output logic                       iq_valid_o,
    input  logic                       iq_ready_i,
    output logic [issue_pkg::XLEN-1:0] iq_pc_o,
    output logic [issue_pkg::ILEN-1:0] iq_instr_o
);

    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    logic [issue_pkg::XLEN-1:0] pc_mem    [IQ_DEPTH];
    logic [issue_pkg::ILEN-1:0] instr_mem [IQ_DEPTH];
    logic [PTR_W-1:0]           head_q;   // oldest entry
    logic [PTR_W-1:0]           tail_q;   // next free slot
    logic [CNT_W-1:0]           count_q;
    logic                       push;
    logic                       pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(IQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign fetch_ready_o = (count_q != CNT_W'(IQ_DEPTH));
    assign iq_valid_o    = (count_q != '0);   // occupancy only
    assign push          = fetch_valid_i && fetch_ready_o;
    assign pop           = iq_ready_i;        // issue logic pops only when valid
    assign iq_pc_o       = pc_mem[head_q];
    assign iq_instr_o    = instr_mem[head_q];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) tail_q <= ptr_inc(tail_q);
            if (pop) head_q <= ptr_inc(head_q);
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            pc_mem[tail_q]    <= fetch_pc_i;
            instr_mem[tail_q] <= fetch_instr_i;
        end
    end

    // dispatch must never be taken from an empty queue
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        iq_ready_i |-> iq_valid_o);

endmodule

/* hw/issue_logic.sv */
`timescale 1ns/1ps
// combinational issue, decodes the queue head and dispatches it to the lowest free station
module issue_logic #(
    parameter int  RS_N  = 4,
    localparam int TAG_W = $clog2(RS_N)
) (
    input  logic                              iq_valid_i,
    output logic                              iq_ready_o,
    input  logic [issue_pkg::ILEN-1:0]        iq_instr_i,
    output logic [issue_pkg::REG_IDX_LEN-1:0] rs1_idx_o,
    output logic [issue_pkg::REG_IDX_LEN-1:0] rs2_idx_o,
    input  logic                              rs1_ready_i,
    input  logic [issue_pkg::XLEN-1:0]        rs1_value_i,
    input  logic [TAG_W-1:0]                  rs1_tag_i,
    input  logic                              rs2_ready_i,
    input  logic [issue_pkg::XLEN-1:0]        rs2_value_i,
    input  logic [TAG_W-1:0]                  rs2_tag_i,
    output logic                              alloc_en_o,
    output logic [issue_pkg::REG_IDX_LEN-1:0] alloc_rd_o,
    output logic [TAG_W-1:0]                  alloc_tag_o,
    input  logic [RS_N-1:0]                   rs_free_i,
    output logic [RS_N-1:0]                   dispatch_o,
    output issue_pkg::alu_op_t                disp_op_o,
    output logic                              disp_rs1_ready_o,
    output logic [issue_pkg::XLEN-1:0]        disp_rs1_value_o,
    output logic [TAG_W-1:0]                  disp_rs1_tag_o,
    output logic                              disp_rs2_ready_o,
    output logic [issue_pkg::XLEN-1:0]        disp_rs2_value_o,
    output logic [TAG_W-1:0]                  disp_rs2_tag_o
);

    issue_pkg::instr_t  instr;
    issue_pkg::alu_op_t op;
    logic               legal;    // head decodes to a supported op
    logic               use_imm;  // addi, immediate replaces rs2
    logic [TAG_W-1:0]   sel;      // lowest free station
    logic               fire;

    assign instr = iq_instr_i;

    always_comb begin
        op      = issue_pkg::ALU_ADD;
        legal   = 1'b0;
        use_imm = 1'b0;
        case (instr.r.opcode)
            issue_pkg::OPC_OP: begin
                legal = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                    10'b0000000_000: op = issue_pkg::ALU_ADD;
                    10'b0100000_000: op = issue_pkg::ALU_SUB;
                    10'b0000000_111: op = issue_pkg::ALU_AND;
                    10'b0000000_110: op = issue_pkg::ALU_OR;
                    10'b0000000_100: op = issue_pkg::ALU_XOR;
                    default:         legal = 1'b0;
                endcase
            end
            issue_pkg::OPC_OP_IMM: begin
                legal   = (instr.i.funct3 == 3'b000); // addi only
                use_imm = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // scan downwards so the lowest free index wins
    always_comb begin
        sel = '0;
        for (int i = RS_N - 1; i >= 0; i--) begin
            if (rs_free_i[i]) sel = TAG_W'(i);
        end
    end

    assign fire       = iq_valid_i && (|rs_free_i) && legal;
    assign iq_ready_o = fire;   // pop and dispatch are one event
    assign dispatch_o = fire ? (RS_N'(1) << sel) : '0;

    assign rs1_idx_o   = instr.r.rs1;
    assign rs2_idx_o   = instr.r.rs2;   // ignored on addi
    assign alloc_en_o  = fire;
    assign alloc_rd_o  = instr.r.rd;
    assign alloc_tag_o = sel;           // station index is the rename tag

    assign disp_op_o        = op;
    assign disp_rs1_ready_o = rs1_ready_i;
    assign disp_rs1_value_o = rs1_value_i;
    assign disp_rs1_tag_o   = rs1_tag_i;
    assign disp_rs2_ready_o = use_imm || rs2_ready_i;
    assign disp_rs2_value_o = use_imm ? {{(issue_pkg::XLEN - 12){instr.i.imm[11]}}, instr.i.imm}
                                      : rs2_value_i;
    assign disp_rs2_tag_o   = rs2_tag_i;

endmodule

/* hw/reg_status_file.sv */
`timescale 1ns/1ps
// architectural registers with busy bit and producer tag, written back from the cdb
module reg_status_file #(
    parameter int  RS_N  = 4,
    localparam int TAG_W = $clog2(RS_N)
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic [issue_pkg::REG_IDX_LEN-1:0] rs1_idx_i,
    output logic                              rs1_ready_o,
    output logic [issue_pkg::XLEN-1:0]        rs1_value_o,
    output logic [TAG_W-1:0]                  rs1_tag_o,
    input  logic [issue_pkg::REG_IDX_LEN-1:0] rs2_idx_i,
    output logic                              rs2_ready_o,
    output logic [issue_pkg::XLEN-1:0]        rs2_value_o,
    output logic [TAG_W-1:0]                  rs2_tag_o,
    input  logic                              alloc_en_i,
    input  logic [issue_pkg::REG_IDX_LEN-1:0] alloc_rd_i,
    input  logic [TAG_W-1:0]                  alloc_tag_i,
    input  logic                              cdb_valid_i,
    input  logic [TAG_W-1:0]                  cdb_tag_i,
    input  logic [issue_pkg::XLEN-1:0]        cdb_value_i,
    input  logic [issue_pkg::REG_IDX_LEN-1:0] cdb_rd_i,
    input  logic [issue_pkg::REG_IDX_LEN-1:0] dbg_idx_i,
    output logic [issue_pkg::XLEN-1:0]        dbg_value_o
);

    localparam int NREG = 2 ** issue_pkg::REG_IDX_LEN;

    logic [issue_pkg::XLEN-1:0] value_q [NREG];
    logic [NREG-1:0]            busy_q;          // waiting on a station
    logic [TAG_W-1:0]           tag_q   [NREG];  // producing station
    logic                       wb_hit;

    // older producers of a renamed register are dropped here
    assign wb_hit = cdb_valid_i && busy_q[cdb_rd_i] && (tag_q[cdb_rd_i] == cdb_tag_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= '0;
            for (int r = 0; r < NREG; r++) begin
                value_q[r] <= '0;
                tag_q[r]   <= '0;
            end
        end else begin
            if (wb_hit) begin
                value_q[cdb_rd_i] <= cdb_value_i;
                busy_q[cdb_rd_i]  <= 1'b0;
            end
            if (alloc_en_i && alloc_rd_i != '0) begin   // later assignment, alloc wins
                busy_q[alloc_rd_i] <= 1'b1;
                tag_q[alloc_rd_i]  <= alloc_tag_i;
            end
        end
    end

    // x0 is never marked busy so it reads zero forever
    assign rs1_ready_o = !busy_q[rs1_idx_i] || (cdb_valid_i && tag_q[rs1_idx_i] == cdb_tag_i);
    assign rs1_value_o = busy_q[rs1_idx_i] ? cdb_value_i : value_q[rs1_idx_i]; // cdb bypass
    assign rs1_tag_o   = tag_q[rs1_idx_i];
    assign rs2_ready_o = !busy_q[rs2_idx_i] || (cdb_valid_i && tag_q[rs2_idx_i] == cdb_tag_i);
    assign rs2_value_o = busy_q[rs2_idx_i] ? cdb_value_i : value_q[rs2_idx_i];
    assign rs2_tag_o   = tag_q[rs2_idx_i];

    assign dbg_value_o = value_q[dbg_idx_i];   // committed value only

endmodule

/* hw/res_station.sv */
`timescale 1ns/1ps
// one-entry reservation station, waits on the cdb for operands, computes, then holds for a grant
module res_station #(
    parameter int  RS_N  = 4,
    localparam int TAG_W = $clog2(RS_N)
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    output logic                              free_o,
    input  logic                              dispatch_i,
    input  issue_pkg::alu_op_t                disp_op_i,
    input  logic                              disp_rs1_ready_i,
    input  logic [issue_pkg::XLEN-1:0]        disp_rs1_value_i,
    input  logic [TAG_W-1:0]                  disp_rs1_tag_i,
    input  logic                              disp_rs2_ready_i,
    input  logic [issue_pkg::XLEN-1:0]        disp_rs2_value_i,
    input  logic [TAG_W-1:0]                  disp_rs2_tag_i,
    input  logic [issue_pkg::REG_IDX_LEN-1:0] disp_rd_i,
    input  logic                              cdb_valid_i,
    input  logic [TAG_W-1:0]                  cdb_tag_i,
    input  logic [issue_pkg::XLEN-1:0]        cdb_value_i,
    output logic                              res_valid_o,
    output logic [issue_pkg::XLEN-1:0]        res_value_o,
    output logic [issue_pkg::REG_IDX_LEN-1:0] res_rd_o,
    input  logic                              grant_i
);

    logic                              busy_q;
    logic                              done_q;     // result waiting for the cdb
    issue_pkg::alu_op_t                op_q;
    logic                              rs1_rdy_q;
    logic                              rs2_rdy_q;
    logic [issue_pkg::XLEN-1:0]        rs1_val_q;
    logic [issue_pkg::XLEN-1:0]        rs2_val_q;
    logic [TAG_W-1:0]                  rs1_tag_q;
    logic [TAG_W-1:0]                  rs2_tag_q;
    logic [issue_pkg::REG_IDX_LEN-1:0] rd_q;
    logic [issue_pkg::XLEN-1:0]        result_q;
    logic [issue_pkg::XLEN-1:0]        alu_out;

    always_comb begin
        case (op_q)
            issue_pkg::ALU_SUB: alu_out = rs1_val_q - rs2_val_q;
            issue_pkg::ALU_AND: alu_out = rs1_val_q & rs2_val_q;
            issue_pkg::ALU_OR:  alu_out = rs1_val_q | rs2_val_q;
            issue_pkg::ALU_XOR: alu_out = rs1_val_q ^ rs2_val_q;
            default:            alu_out = rs1_val_q + rs2_val_q;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
        end else if (dispatch_i) begin
            busy_q    <= 1'b1;
            done_q    <= 1'b0;
            op_q      <= disp_op_i;
            rs1_rdy_q <= disp_rs1_ready_i;
            rs1_val_q <= disp_rs1_value_i;
            rs1_tag_q <= disp_rs1_tag_i;
            rs2_rdy_q <= disp_rs2_ready_i;
            rs2_val_q <= disp_rs2_value_i;
            rs2_tag_q <= disp_rs2_tag_i;
            rd_q      <= disp_rd_i;
        end else if (busy_q) begin
            if (cdb_valid_i && !rs1_rdy_q && cdb_tag_i == rs1_tag_q) begin   // snoop
                rs1_rdy_q <= 1'b1;
                rs1_val_q <= cdb_value_i;
            end
            if (cdb_valid_i && !rs2_rdy_q && cdb_tag_i == rs2_tag_q) begin
                rs2_rdy_q <= 1'b1;
                rs2_val_q <= cdb_value_i;
            end
            if (rs1_rdy_q && rs2_rdy_q && !done_q) begin   // execute, one cycle
                result_q <= alu_out;
                done_q   <= 1'b1;
            end
            if (grant_i) begin   // on the cdb this cycle, free at the edge
                busy_q <= 1'b0;
                done_q <= 1'b0;
            end
        end
    end

    assign free_o      = !busy_q;
    assign res_valid_o = done_q;
    assign res_value_o = result_q;
    assign res_rd_o    = rd_q;

    a_no_disp_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        dispatch_i |-> !busy_q);
    a_grant_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        grant_i |-> res_valid_o);

endmodule

/* hw/cdb_arbiter.sv */
`timescale 1ns/1ps
// round-robin pick of one finished station per cycle to drive the cdb
module cdb_arbiter #(
    parameter int  RS_N  = 4,
    localparam int TAG_W = $clog2(RS_N)
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [RS_N-1:0]  res_valid_i,
    output logic [RS_N-1:0]  grant_o,
    output logic             cdb_valid_o,
    output logic [TAG_W-1:0] cdb_tag_o
);

    logic [TAG_W-1:0] last_q;   // last granted station
    logic [TAG_W-1:0] idx;
    logic [TAG_W-1:0] sel;
    logic             found;

    // search starts one past the last grant
    always_comb begin
        found = 1'b0;
        sel   = last_q;
        idx   = last_q;
        for (int k = 1; k <= RS_N; k++) begin
            idx = TAG_W'((int'(last_q) + k) % RS_N);
            if (!found && res_valid_i[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    assign cdb_valid_o = found;
    assign cdb_tag_o   = sel;
    assign grant_o     = found ? (RS_N'(1) << sel) : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) last_q <= TAG_W'(RS_N - 1);   // station 0 goes first
        else if (found) last_q <= sel;
    end

    // a result not granted is still offered next cycle
    a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        ($past(res_valid_i & ~grant_o) & ~res_valid_i) == '0);

endmodule

/* hw/issue_stage_top.sv */
`timescale 1ns/1ps
// issue stage top, fetch enters the queue and results leave on the cdb; the testbench instantiates it
module issue_stage_top #(
    parameter int IQ_DEPTH = 4,
    parameter int RS_N     = 4
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              fetch_valid_i,
    output logic                              fetch_ready_o,
    input  logic [issue_pkg::XLEN-1:0]        fetch_pc_i,
    input  logic [issue_pkg::ILEN-1:0]        fetch_instr_i,
    output logic                              cdb_valid_o,
    output logic [issue_pkg::REG_IDX_LEN-1:0] cdb_rd_o,
    output logic [issue_pkg::XLEN-1:0]        cdb_value_o,
    output logic                              busy_o,
    input  logic [issue_pkg::REG_IDX_LEN-1:0] dbg_idx_i,
    output logic [issue_pkg::XLEN-1:0]        dbg_value_o
);

    localparam int TAG_W = $clog2(RS_N);

    logic                              iq_valid;
    logic                              iq_ready;
    logic [issue_pkg::ILEN-1:0]        iq_instr;
    logic [issue_pkg::REG_IDX_LEN-1:0] rs1_idx;
    logic [issue_pkg::REG_IDX_LEN-1:0] rs2_idx;
    logic                              rs1_ready;
    logic                              rs2_ready;
    logic [issue_pkg::XLEN-1:0]        rs1_value;
    logic [issue_pkg::XLEN-1:0]        rs2_value;
    logic [TAG_W-1:0]                  rs1_tag;
    logic [TAG_W-1:0]                  rs2_tag;
    logic                              alloc_en;
    logic [issue_pkg::REG_IDX_LEN-1:0] alloc_rd;   // also the rd handed to the station
    logic [TAG_W-1:0]                  alloc_tag;
    logic [RS_N-1:0]                   rs_free;
    logic [RS_N-1:0]                   dispatch;
    issue_pkg::alu_op_t                disp_op;
    logic                              disp_rs1_ready;
    logic                              disp_rs2_ready;
    logic [issue_pkg::XLEN-1:0]        disp_rs1_value;
    logic [issue_pkg::XLEN-1:0]        disp_rs2_value;
    logic [TAG_W-1:0]                  disp_rs1_tag;
    logic [TAG_W-1:0]                  disp_rs2_tag;
    logic [RS_N-1:0]                   res_valid;
    logic [RS_N-1:0]                   grant;
    logic [issue_pkg::XLEN-1:0]        res_value [RS_N];
    logic [issue_pkg::REG_IDX_LEN-1:0] res_rd    [RS_N];
    logic [TAG_W-1:0]                  cdb_tag;

    issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_issue_queue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_instr_i (fetch_instr_i),
        .iq_valid_o    (iq_valid),
        .iq_ready_i    (iq_ready),
        .iq_pc_o       (),              // alu ops need no pc
        .iq_instr_o    (iq_instr)
    );

    issue_logic #(.RS_N(RS_N)) u_issue_logic (
        .iq_valid_i       (iq_valid),
        .iq_ready_o       (iq_ready),
        .iq_instr_i       (iq_instr),
        .rs1_idx_o        (rs1_idx),
        .rs2_idx_o        (rs2_idx),
        .rs1_ready_i      (rs1_ready),
        .rs1_value_i      (rs1_value),
        .rs1_tag_i        (rs1_tag),
        .rs2_ready_i      (rs2_ready),
        .rs2_value_i      (rs2_value),
        .rs2_tag_i        (rs2_tag),
        .alloc_en_o       (alloc_en),
        .alloc_rd_o       (alloc_rd),
        .alloc_tag_o      (alloc_tag),
        .rs_free_i        (rs_free),
        .dispatch_o       (dispatch),
        .disp_op_o        (disp_op),
        .disp_rs1_ready_o (disp_rs1_ready),
        .disp_rs1_value_o (disp_rs1_value),
        .disp_rs1_tag_o   (disp_rs1_tag),
        .disp_rs2_ready_o (disp_rs2_ready),
        .disp_rs2_value_o (disp_rs2_value),
        .disp_rs2_tag_o   (disp_rs2_tag)
    );

    reg_status_file #(.RS_N(RS_N)) u_reg_status_file (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rs1_idx_i   (rs1_idx),
        .rs1_ready_o (rs1_ready),
        .rs1_value_o (rs1_value),
        .rs1_tag_o   (rs1_tag),
        .rs2_idx_i   (rs2_idx),
        .rs2_ready_o (rs2_ready),
        .rs2_value_o (rs2_value),
        .rs2_tag_o   (rs2_tag),
        .alloc_en_i  (alloc_en),
        .alloc_rd_i  (alloc_rd),
        .alloc_tag_i (alloc_tag),
        .cdb_valid_i (cdb_valid_o),
        .cdb_tag_i   (cdb_tag),
        .cdb_value_i (cdb_value_o),
        .cdb_rd_i    (cdb_rd_o),
        .dbg_idx_i   (dbg_idx_i),
        .dbg_value_o (dbg_value_o)
    );

    for (genvar s = 0; s < RS_N; s++) begin : g_rs
        res_station #(.RS_N(RS_N)) u_res_station (
            .clk_i            (clk_i),
            .rst_i            (rst_i),
            .free_o           (rs_free[s]),
            .dispatch_i       (dispatch[s]),
            .disp_op_i        (disp_op),
            .disp_rs1_ready_i (disp_rs1_ready),
            .disp_rs1_value_i (disp_rs1_value),
            .disp_rs1_tag_i   (disp_rs1_tag),
            .disp_rs2_ready_i (disp_rs2_ready),
            .disp_rs2_value_i (disp_rs2_value),
            .disp_rs2_tag_i   (disp_rs2_tag),
            .disp_rd_i        (alloc_rd),
            .cdb_valid_i      (cdb_valid_o),
            .cdb_tag_i        (cdb_tag),
            .cdb_value_i      (cdb_value_o),
            .res_valid_o      (res_valid[s]),
            .res_value_o      (res_value[s]),
            .res_rd_o         (res_rd[s]),
            .grant_i          (grant[s])
        );
    end

    cdb_arbiter #(.RS_N(RS_N)) u_cdb_arbiter (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .res_valid_i (res_valid),
        .grant_o     (grant),
        .cdb_valid_o (cdb_valid_o),
        .cdb_tag_o   (cdb_tag)
    );

    assign cdb_value_o = res_value[cdb_tag];   // granted station drives the bus
    assign cdb_rd_o    = res_rd[cdb_tag];
    assign busy_o      = iq_valid || !(&rs_free);

endmodule

/* testbench/tb_issue_stage.sv */
// testbench for the issue stage, streams random alu programs and checks the cdb and final registers
`timescale 1ns/1ps
module tb_issue_stage;

    localparam int CLK_PERIOD      = 100;
    localparam int N_SEED          = 31;   // one addi per register
    localparam int N_MIX           = 48;   // random ops on a few registers
    localparam int N_CHAIN         = 24;   // dependent burst, fills the stations
    localparam int N_WAW           = 12;
    localparam int N_TOTAL         = N_SEED + N_MIX + N_CHAIN + N_WAW;
    localparam int WATCHDOG_CYCLES = 50 * N_TOTAL + 200;

    localparam int OP_ADD  = 0;
    localparam int OP_SUB  = 1;
    localparam int OP_AND  = 2;
    localparam int OP_OR   = 3;
    localparam int OP_XOR  = 4;
    localparam int OP_ADDI = 5;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        fetch_valid_i;
    logic        fetch_ready_o;
    logic [31:0] fetch_pc_i;
    logic [31:0] fetch_instr_i;
    logic        cdb_valid_o;
    logic [4:0]  cdb_rd_o;
    logic [31:0] cdb_value_o;
    logic        busy_o;
    logic [4:0]  dbg_idx_i;
    logic [31:0] dbg_value_o;

    logic [31:0] model [32];      // register state in program order
    logic [36:0] pending [$];     // {rd, value} still owed by the cdb
    int          seed       = 32'h6e9f;
    logic [31:0] pc         = '0;
    int          errors     = 0;
    int          sent       = 0;
    int          retired    = 0;
    int          hit_idx;
    logic [31:0] exp_val;
    logic        rst_q      = 1'b0;
    logic        rst_qq     = 1'b0;
    logic        beat_valid = 1'b0; // cdb beat seen at the last rising edge
    logic        beat_hit   = 1'b0;
    logic        beat_known = 1'b0;
    logic [4:0]  beat_rd;
    logic [31:0] beat_value;
    logic [31:0] beat_exp;
    logic        saw_full   = 1'b0;
    logic        chain_full = 1'b0; // queue filled while the chain was streaming
    logic        drain_chk  = 1'b0;
    int          pend_left  = 0;
    logic        dbg_chk    = 1'b0;
    logic [31:0] dbg_exp;

    issue_stage_top #(.IQ_DEPTH(4), .RS_N(4)) dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_instr_i (fetch_instr_i),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_rd_o      (cdb_rd_o),
        .cdb_value_o   (cdb_value_o),
        .busy_o        (busy_o),
        .dbg_idx_i     (dbg_idx_i),
        .dbg_value_o   (dbg_value_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] encode(input int op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        case (op)
            OP_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, issue_pkg::OPC_OP};
            OP_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, issue_pkg::OPC_OP};
            OP_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, issue_pkg::OPC_OP};
            OP_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, issue_pkg::OPC_OP};
            OP_ADDI: return {imm, rs1, 3'b000, rd, issue_pkg::OPC_OP_IMM};
            default: return {7'b0000000, rs2, rs1, 3'b000, rd, issue_pkg::OPC_OP};
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return a + b;   // add and addi
        endcase
    endfunction

    function automatic int find_pending(input logic [4:0] rd, input logic [31:0] value);
        for (int k = 0; k < pending.size(); k++) begin
            if (pending[k] == {rd, value}) return k;
        end
        return -1;
    endfunction

    // oldest outstanding value for rd, for the error line
    function automatic logic expected_for(input logic [4:0] rd, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < pending.size(); k++) begin
            if (pending[k][36:32] == rd) begin
                value = pending[k][31:0];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic push_fetch(input logic [31:0] word);
        fetch_valid_i = 1'b1;
        fetch_instr_i = word;
        fetch_pc_i    = pc;
        while (!fetch_ready_o) begin   // queue full, hold the request
            saw_full = 1'b1;
            @(negedge clk_i);
        end
        @(negedge clk_i);              // taken at the rising edge in between
        fetch_valid_i = 1'b0;
        pc = pc + 32'd4;
    endtask

    task automatic issue_op(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] b;
        logic [31:0] res;
        b   = (op == OP_ADDI) ? {{20{imm[11]}}, imm} : model[rs2];
        res = alu_ref(op, model[rs1], b);
        if (rd != 5'd0) model[rd] = res;   // x0 stays zero
        pending.push_back({rd, res});
        sent++;
        push_fetch(encode(op, rd, rs1, rs2, imm));
    endtask

    always @(posedge clk_i) begin
        rst_q  <= rst_i;
        rst_qq <= rst_q;
    end

    // retire each cdb beat against the list, flags are checked on the falling edge
    always @(posedge clk_i) begin
        beat_valid <= cdb_valid_o && !rst_i;
        beat_rd    <= cdb_rd_o;
        beat_value <= cdb_value_o;
        if (cdb_valid_o && !rst_i) begin
            hit_idx = find_pending(cdb_rd_o, cdb_value_o);
            beat_hit   <= (hit_idx >= 0);
            beat_known <= expected_for(cdb_rd_o, exp_val);
            beat_exp   <= exp_val;
            if (hit_idx >= 0) begin
                pending.delete(hit_idx);
                retired++;
            end
        end
    end

    a_reset_state: assert property (@(negedge clk_i)
        (rst_q || rst_qq) |-> (!cdb_valid_o && !busy_o && fetch_ready_o))
    else begin
        errors++;
        $display("outputs not in reset state at %0t: cdb_valid_o=%b busy_o=%b fetch_ready_o=%b",
                 $time, cdb_valid_o, busy_o, fetch_ready_o);
    end

    a_cdb_beat: assert property (@(negedge clk_i) beat_valid |-> beat_hit)
    else begin
        errors++;
        if (beat_known)
            $display("Mismatch at %0t: cdb_value_o for x%0d got %h expected %h",
                     $time, beat_rd, beat_value, beat_exp);
        else
            $display("cdb result %h for x%0d at %0t matches no outstanding instruction",
                     beat_value, beat_rd, $time);
    end

    a_reg_read: assert property (@(posedge clk_i) dbg_chk |-> dbg_value_o == dbg_exp)
    else begin
        errors++;
        $display("Mismatch at %0t: dbg_value_o for x%0d got %h expected %h",
                 $time, dbg_idx_i, dbg_value_o, dbg_exp);
    end

    a_drained: assert property (@(posedge clk_i) drain_chk |-> pend_left == 0)
    else begin
        errors++;
        $display("%0d results never appeared on the cdb before busy_o fell", pend_left);
    end

    a_backpressure: assert property (@(posedge clk_i) drain_chk |-> chain_full)
    else begin
        errors++;
        $display("fetch_ready_o never dropped during the dependent burst");
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired at %0t with %0d results outstanding", $time, pending.size());
        $display("%0d of %0d instructions retired, %0d errors", retired, sent, errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        rst_i         = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_instr_i = '0;
        dbg_idx_i     = '0;
        for (int r = 0; r < 32; r++) model[r] = '0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        repeat (2) @(negedge clk_i);   // idle cycle after reset is checked too

        // independent results, every register loaded from x0
        for (int r = 1; r < 32; r++) begin
            rnd = $random(seed);
            issue_op(OP_ADDI, 5'(r), 5'd0, 5'd0, rnd[11:0]);
        end

        // raw chains on x0..x7, forwarding and bypass
        for (int n = 0; n < N_MIX; n++) begin
            rnd = $random(seed);
            issue_op(int'(rnd[2:0]) % 6, {2'b00, rnd[5:3]}, {2'b00, rnd[8:6]},
                     {2'b00, rnd[11:9]}, rnd[23:12]);
        end

        saw_full = 1'b0;
        for (int n = 0; n < N_CHAIN; n++) begin
            rnd = $random(seed);
            issue_op(int'(rnd[2:0]) % 6, 5'd10, 5'd10, 5'd9, rnd[14:3]);   // each waits on the last
        end
        chain_full = saw_full;

        for (int n = 0; n < N_WAW; n++) begin
            rnd = $random(seed);
            case (n % 3)
                0:       issue_op(OP_ADD, 5'd12, 5'd10, 5'd12, 12'd0);      // slow writer
                1:       issue_op(OP_ADDI, 5'd12, 5'd3, 5'd0, rnd[11:0]);   // fast, may finish first
                default: issue_op(OP_XOR, 5'd0, 5'd12, 5'd5, 12'd0);        // result thrown away
            endcase
        end

        while (busy_o) @(negedge clk_i);
        pend_left = pending.size();
        drain_chk = 1'b1;
        @(negedge clk_i);
        drain_chk = 1'b0;

        for (int r = 0; r < 32; r++) begin
            dbg_idx_i = 5'(r);
            dbg_exp   = model[r];
            dbg_chk   = 1'b1;
            @(negedge clk_i);
        end
        dbg_chk = 1'b0;

        $display("%0d of %0d instructions retired, %0d errors", retired, sent, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* filelist.f */
hw/issue_pkg.sv
hw/issue_queue.sv
hw/issue_logic.sv
hw/reg_status_file.sv
hw/res_station.sv
hw/cdb_arbiter.sv
hw/issue_stage_top.sv
testbench/tb_issue_stage.sv

/* run_sim.sh */
#!/bin/sh
# build the issue stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_issue_stage -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_issue_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
